/* include/mem_consts.svh */
//**********************************************************************
// address window and RAM depth shared by the memory stage
// RAM_BASE must be 8-byte aligned; the window is 8 << RAM_INDEX_W bytes
//**********************************************************************
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address of the first RAM byte
`define RAM_BASE 64'h0000_0000_8000_0000

// doubleword index width, 1024 dwords of RAM
`define RAM_INDEX_W 10

// data path width
`define XLEN 64

`endif

/* src/mem_types_pkg.sv */
//**********************************************************************
// address, data and access-size types of the memory stage
// widths follow mem_consts.svh
//**********************************************************************
`include "mem_consts.svh"

package mem_types_pkg;

    typedef logic [`XLEN-1:0]        addr_t;
    typedef logic [`XLEN-1:0]        dword_t;
    typedef logic [31:0]             inst_t;
    typedef logic [7:0]              byte_mask_t;
    typedef logic [`RAM_INDEX_W-1:0] ram_index_t;

    // natural access sizes, 1, 2, 4 and 8 bytes
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_e;

endpackage

/* src/arb_types_pkg.sv */
//**********************************************************************
// requester ids and port states used around the RAM arbiter
//**********************************************************************
package arb_types_pkg;

    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_LSU   = 1'b1
    } req_id_e;

    // idle, or holding one response
    typedef enum logic {
        PORT_IDLE = 1'b0,
        PORT_RESP = 1'b1
    } port_state_e;

endpackage

/* src/lsu_port.sv */
//**********************************************************************
// load/store requester; one access in flight, loads are zero-extended
// misaligned or out-of-window accesses get err and never reach the RAM
//**********************************************************************
`timescale 1ns/1ps
`include "mem_consts.svh"

module lsu_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        lsu_req_valid,
    output logic                        lsu_req_ready,
    input  logic                        lsu_req_write,
    input  mem_types_pkg::addr_t        lsu_req_addr,
    input  mem_types_pkg::access_size_e lsu_req_size,
    input  mem_types_pkg::dword_t       lsu_req_wdata,
    output logic                        lsu_rsp_valid,
    input  logic                        lsu_rsp_ready,
    output mem_types_pkg::dword_t       lsu_rsp_rdata,
    output logic                        lsu_rsp_err,
    output logic                        lsu_bus_valid,
    input  logic                        lsu_bus_ready,
    output logic                        lsu_bus_write,
    output mem_types_pkg::ram_index_t   lsu_bus_index,
    output mem_types_pkg::dword_t       lsu_bus_wdata,
    output mem_types_pkg::byte_mask_t   lsu_bus_mask,
    input  mem_types_pkg::dword_t       ram_rdata
);
    localparam int WIN_W = `RAM_INDEX_W + 3;

    arb_types_pkg::port_state_e  state_q;
    mem_types_pkg::addr_t        win_off;
    logic                        aligned;
    logic                        legal;
    logic                        req_fire;
    mem_types_pkg::byte_mask_t   size_mask;
    mem_types_pkg::dword_t       wdata_rep;
    mem_types_pkg::access_size_e size_q;
    logic [2:0]                  offset_q;
    logic                        err_q;
    logic                        write_q;
    logic                        fresh_q;
    mem_types_pkg::dword_t       lane_data;
    mem_types_pkg::dword_t       load_data;
    mem_types_pkg::dword_t       rdata_q;

    // wraps to a huge offset below the base
    assign win_off = lsu_req_addr - `RAM_BASE;

    always_comb begin
        case (lsu_req_size)
            mem_types_pkg::SIZE_B: begin
                aligned   = 1'b1;
                size_mask = 8'h01;
                wdata_rep = {8{lsu_req_wdata[7:0]}};
            end
            mem_types_pkg::SIZE_H: begin
                aligned   = (lsu_req_addr[0] == 1'b0);
                size_mask = 8'h03;
                wdata_rep = {4{lsu_req_wdata[15:0]}};
            end
            mem_types_pkg::SIZE_W: begin
                aligned   = (lsu_req_addr[1:0] == 2'b00);
                size_mask = 8'h0f;
                wdata_rep = {2{lsu_req_wdata[31:0]}};
            end
            default: begin
                aligned   = (lsu_req_addr[2:0] == 3'b000);
                size_mask = 8'hff;
                wdata_rep = lsu_req_wdata;
            end
        endcase
    end

    assign legal = aligned && (win_off[`XLEN-1:WIN_W] == '0);

    // legal accesses wait for the grant, illegal ones are taken at once
    assign lsu_bus_valid = (state_q == arb_types_pkg::PORT_IDLE) && lsu_req_valid && legal;
    assign lsu_req_ready = (state_q == arb_types_pkg::PORT_IDLE) && lsu_req_valid &&
                           (legal ? lsu_bus_ready : 1'b1);
    assign req_fire      = lsu_req_valid && lsu_req_ready;

    assign lsu_bus_write = lsu_req_write;
    assign lsu_bus_index = win_off[WIN_W-1:3];
    assign lsu_bus_wdata = wdata_rep;
    assign lsu_bus_mask  = size_mask << lsu_req_addr[2:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= arb_types_pkg::PORT_IDLE;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= req_fire;
            case (state_q)
                arb_types_pkg::PORT_IDLE: begin
                    if (req_fire) begin
                        state_q <= arb_types_pkg::PORT_RESP;
                    end
                end
                default: begin
                    if (lsu_rsp_ready) begin
                        state_q <= arb_types_pkg::PORT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            size_q   <= lsu_req_size;
            offset_q <= lsu_req_addr[2:0];
            err_q    <= !legal;
            write_q  <= lsu_req_write;
        end
    end

    // lane select, then zero-extend by size
    assign lane_data = ram_rdata >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            mem_types_pkg::SIZE_B: load_data = {56'd0, lane_data[7:0]};
            mem_types_pkg::SIZE_H: load_data = {48'd0, lane_data[15:0]};
            mem_types_pkg::SIZE_W: load_data = {32'd0, lane_data[31:0]};
            default:               load_data = lane_data;
        endcase
        if (err_q || write_q) begin
            load_data = '0;
        end
    end

    // ram_rdata is only valid in the first response cycle
    always_ff @(posedge clk) begin
        if (fresh_q) begin
            rdata_q <= load_data;
        end
    end

    assign lsu_rsp_valid = (state_q == arb_types_pkg::PORT_RESP);
    assign lsu_rsp_rdata = fresh_q ? load_data : rdata_q;
    assign lsu_rsp_err   = err_q;

    rsp_held_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        lsu_rsp_valid && !lsu_rsp_ready |=>
            lsu_rsp_valid && $stable(lsu_rsp_rdata) && $stable(lsu_rsp_err)
    ) else $error("lsu response dropped or changed before rsp_ready");

endmodule

/* src/fetch_port.sv */
//**********************************************************************
// instruction requester; 4-byte aligned fetches inside the RAM window
// one fetch in flight, the response waits for if_rsp_ready
//**********************************************************************
`timescale 1ns/1ps
`include "mem_consts.svh"

module fetch_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      if_req_valid,
    output logic                      if_req_ready,
    input  mem_types_pkg::addr_t      if_req_addr,
    output logic                      if_rsp_valid,
    input  logic                      if_rsp_ready,
    output mem_types_pkg::inst_t      if_rsp_inst,
    output logic                      if_rsp_err,
    output logic                      if_bus_valid,
    input  logic                      if_bus_ready,
    output mem_types_pkg::ram_index_t if_bus_index,
    input  mem_types_pkg::dword_t     ram_rdata
);
    localparam int WIN_W = `RAM_INDEX_W + 3;

    arb_types_pkg::port_state_e state_q;
    mem_types_pkg::addr_t       win_off;
    logic                       legal;
    logic                       req_fire;
    logic                       half_q;
    logic                       err_q;
    logic                       fresh_q;
    mem_types_pkg::inst_t       inst_sel;
    mem_types_pkg::inst_t       inst_q;

    assign win_off = if_req_addr - `RAM_BASE;
    assign legal   = (if_req_addr[1:0] == 2'b00) && (win_off[`XLEN-1:WIN_W] == '0);

    assign if_bus_valid = (state_q == arb_types_pkg::PORT_IDLE) && if_req_valid && legal;
    assign if_req_ready = (state_q == arb_types_pkg::PORT_IDLE) && if_req_valid &&
                          (legal ? if_bus_ready : 1'b1);
    assign req_fire     = if_req_valid && if_req_ready;
    assign if_bus_index = win_off[WIN_W-1:3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= arb_types_pkg::PORT_IDLE;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= req_fire;
            if (state_q == arb_types_pkg::PORT_IDLE && req_fire) begin
                state_q <= arb_types_pkg::PORT_RESP;
            end else if (state_q == arb_types_pkg::PORT_RESP && if_rsp_ready) begin
                state_q <= arb_types_pkg::PORT_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            half_q <= if_req_addr[2];
            err_q  <= !legal;
        end
    end

    // addr[2] picks the upper word
    assign inst_sel = err_q ? '0 : (half_q ? ram_rdata[63:32] : ram_rdata[31:0]);

    always_ff @(posedge clk) begin
        if (fresh_q) begin
            inst_q <= inst_sel;
        end
    end

    assign if_rsp_valid = (state_q == arb_types_pkg::PORT_RESP);
    assign if_rsp_inst  = fresh_q ? inst_sel : inst_q;
    assign if_rsp_err   = err_q;

endmodule

/* src/mem_arbiter.sv */
//**********************************************************************
// round-robin arbiter for the shared RAM with one grant per cycle
// fetch wins the first contended cycle after reset
//**********************************************************************
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      if_bus_valid,
    output logic                      if_bus_ready,
    input  mem_types_pkg::ram_index_t if_bus_index,
    input  logic                      lsu_bus_valid,
    output logic                      lsu_bus_ready,
    input  logic                      lsu_bus_write,
    input  mem_types_pkg::ram_index_t lsu_bus_index,
    input  mem_types_pkg::dword_t     lsu_bus_wdata,
    input  mem_types_pkg::byte_mask_t lsu_bus_mask,
    output logic                      ram_en,
    output logic                      ram_we,
    output mem_types_pkg::ram_index_t ram_index,
    output mem_types_pkg::dword_t     ram_wdata,
    output mem_types_pkg::byte_mask_t ram_mask
);
    arb_types_pkg::req_id_e last_q;
    arb_types_pkg::req_id_e grant_id;
    logic                   grant_any;

    always_comb begin
        grant_any = if_bus_valid || lsu_bus_valid;
        if (if_bus_valid && lsu_bus_valid) begin
            // on contention the one not served last goes
            grant_id = (last_q == arb_types_pkg::REQ_FETCH) ? arb_types_pkg::REQ_LSU
                                                            : arb_types_pkg::REQ_FETCH;
        end else if (lsu_bus_valid) begin
            grant_id = arb_types_pkg::REQ_LSU;
        end else begin
            grant_id = arb_types_pkg::REQ_FETCH;
        end
    end

    assign if_bus_ready  = grant_any && (grant_id == arb_types_pkg::REQ_FETCH);
    assign lsu_bus_ready = grant_any && (grant_id == arb_types_pkg::REQ_LSU);

    // starts as lsu so that fetch has priority first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= arb_types_pkg::REQ_LSU;
        end else if (grant_any) begin
            last_q <= grant_id;
        end
    end

    // fetch is read-only
    assign ram_en    = grant_any;
    assign ram_we    = lsu_bus_ready && lsu_bus_write;
    assign ram_index = lsu_bus_ready ? lsu_bus_index : if_bus_index;
    assign ram_wdata = lsu_bus_wdata;
    assign ram_mask  = lsu_bus_ready ? lsu_bus_mask : 8'hff;

    // a requester passed over once is served on its next cycle
    if_turn_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        if_bus_valid && !if_bus_ready |=> !if_bus_valid || if_bus_ready
    ) else $error("fetch passed over two cycles in a row");

    lsu_turn_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        lsu_bus_valid && !lsu_bus_ready |=> !lsu_bus_valid || lsu_bus_ready
    ) else $error("lsu passed over two cycles in a row");

endmodule

/* src/data_ram.sv */
//**********************************************************************
// 64-bit single-port RAM, byte-lane writes, registered read data
// ram_rdata changes only on cycles after ram_en; contents start cleared
//**********************************************************************
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_ram (
    input  logic                      clk,
    input  logic                      ram_en,
    input  logic                      ram_we,
    input  mem_types_pkg::ram_index_t ram_index,
    input  mem_types_pkg::dword_t     ram_wdata,
    input  mem_types_pkg::byte_mask_t ram_mask,
    output mem_types_pkg::dword_t     ram_rdata
);
    localparam int DEPTH = 1 << `RAM_INDEX_W;

    mem_types_pkg::dword_t mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int b = 0; b < 8; b++) begin
                    if (ram_mask[b]) begin
                        mem[ram_index][8*b +: 8] <= ram_wdata[8*b +: 8];
                    end
                end
            end
            // old contents on a write cycle
            ram_rdata <= mem[ram_index];
        end
    end

    // a store that reaches the RAM always touches at least one lane
    write_mask_a: assert property (
        @(posedge clk)
        ram_en && ram_we |-> ram_mask != '0
    ) else $error("RAM write with empty byte mask");

endmodule

/* src/mem_subsys_top.sv */
//**********************************************************************
// memory stage top: fetch and load/store ports sharing one data RAM
// each port has at most one request in flight
//**********************************************************************
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        lsu_req_valid,
    output logic                        lsu_req_ready,
    input  logic                        lsu_req_write,
    input  mem_types_pkg::addr_t        lsu_req_addr,
    input  mem_types_pkg::access_size_e lsu_req_size,
    input  mem_types_pkg::dword_t       lsu_req_wdata,
    output logic                        lsu_rsp_valid,
    input  logic                        lsu_rsp_ready,
    output mem_types_pkg::dword_t       lsu_rsp_rdata,
    output logic                        lsu_rsp_err,
    input  logic                        if_req_valid,
    output logic                        if_req_ready,
    input  mem_types_pkg::addr_t        if_req_addr,
    output logic                        if_rsp_valid,
    input  logic                        if_rsp_ready,
    output mem_types_pkg::inst_t        if_rsp_inst,
    output logic                        if_rsp_err
);
    logic                      if_bus_valid;
    logic                      if_bus_ready;
    mem_types_pkg::ram_index_t if_bus_index;
    logic                      lsu_bus_valid;
    logic                      lsu_bus_ready;
    logic                      lsu_bus_write;
    mem_types_pkg::ram_index_t lsu_bus_index;
    mem_types_pkg::dword_t     lsu_bus_wdata;
    mem_types_pkg::byte_mask_t lsu_bus_mask;
    logic                      ram_en;
    logic                      ram_we;
    mem_types_pkg::ram_index_t ram_index;
    mem_types_pkg::dword_t     ram_wdata;
    mem_types_pkg::byte_mask_t ram_mask;
    mem_types_pkg::dword_t     ram_rdata;

    fetch_port u_fetch_port (.*);

    lsu_port u_lsu_port (.*);

    mem_arbiter u_mem_arbiter (.*);

    // read data goes to both ports, each knows when it is its own
    data_ram u_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_mask  (ram_mask),
        .ram_rdata (ram_rdata)
    );

endmodule

/* tb/tb_mem_subsys.sv */
//**********************************************************************
// random traffic on both ports checked against a byte-array model
// legal traffic stays in the low 256 bytes of the window to hit reuse
//**********************************************************************
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsys;
    localparam int WIN_BYTES   = 8 << `RAM_INDEX_W;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_SAT    = 1;
    localparam int MODE_HOLD   = 2;
    localparam int MODE_DRAIN  = 3;

    logic clk;
    logic rst_n;
    logic lsu_req_valid;
    logic lsu_req_ready;
    logic lsu_req_write;
    mem_types_pkg::addr_t        lsu_req_addr;
    mem_types_pkg::access_size_e lsu_req_size;
    mem_types_pkg::dword_t       lsu_req_wdata;
    logic                        lsu_rsp_valid;
    logic                        lsu_rsp_ready;
    mem_types_pkg::dword_t       lsu_rsp_rdata;
    logic                        lsu_rsp_err;
    logic                        if_req_valid;
    logic                        if_req_ready;
    mem_types_pkg::addr_t        if_req_addr;
    logic                        if_rsp_valid;
    logic                        if_rsp_ready;
    mem_types_pkg::inst_t        if_rsp_inst;
    logic                        if_rsp_err;

    integer seed = 43444;
    int     mode = MODE_DRAIN;
    logic   count_alt = 1'b0;
    int     error_count = 0;
    int     check_count = 0;
    int     last_port = -1;
    int     sat_fires = 0;
    int     hold_cycles = 0;
    int     hold_fetch_done = 0;
    logic [7:0] model [WIN_BYTES];

    // fetch expects {err, inst} and lsu expects {check data, err, data}
    logic [32:0] if_exp_q[$];
    logic [65:0] lsu_exp_q[$];

    // acceptance as seen at the last falling edge
    logic        if_fire = 1'b0;
    logic        if_held = 1'b0;
    logic [31:0] if_inst_prev;
    logic        if_err_prev;
    logic        lsu_fire = 1'b0;
    logic        lsu_held = 1'b0;
    logic [63:0] lsu_rdata_prev;
    logic        lsu_err_prev;

    mem_subsys_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    function automatic bit access_legal(input mem_types_pkg::addr_t addr, input int nbytes);
        mem_types_pkg::addr_t off;
        off = addr - `RAM_BASE;
        return (off < WIN_BYTES) && ((addr % nbytes) == 0);
    endfunction

    function automatic logic [63:0] model_read(input mem_types_pkg::addr_t addr,
                                               input int nbytes);
        logic [63:0] val;
        int          off;
        val = '0;
        off = int'(addr - `RAM_BASE);
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = model[off + i];
        end
        return val;
    endfunction

    task automatic model_write(input mem_types_pkg::addr_t addr, input int nbytes,
                               input logic [63:0] data);
        int off;
        off = int'(addr - `RAM_BASE);
        for (int i = 0; i < nbytes; i++) begin
            model[off + i] = data[8*i +: 8];
        end
    endtask

    function automatic mem_types_pkg::addr_t outside_addr();
        int pick;
        pick = $unsigned($random(seed)) % 3;
        if (pick == 0) begin
            return `RAM_BASE - 64'd8;
        end else if (pick == 1) begin
            return `RAM_BASE + WIN_BYTES + 64'd16;
        end
        return 64'h0;
    endfunction

    task automatic next_fetch();
        int                   kind;
        mem_types_pkg::addr_t addr;
        kind = $unsigned($random(seed)) % 8;
        addr = `RAM_BASE + ($unsigned($random(seed)) % 64) * 4;
        if (mode != MODE_SAT && kind == 0) begin
            addr = addr + 1 + ($unsigned($random(seed)) % 3);
        end else if (mode != MODE_SAT && kind == 1) begin
            addr = outside_addr();
        end
        if_req_addr  <= addr;
        if_req_valid <= 1'b1;
    endtask

    task automatic next_lsu();
        int                   kind;
        logic [1:0]           sz;
        mem_types_pkg::addr_t addr;
        kind = $unsigned($random(seed)) % 8;
        sz   = $random(seed);
        addr = `RAM_BASE + ($unsigned($random(seed)) % 256);
        addr = addr & ~((64'd1 << sz) - 64'd1);
        if (mode != MODE_SAT && kind == 0 && sz != 2'd0) begin
            addr = addr | 64'd1;
        end else if (mode != MODE_SAT && kind == 1) begin
            addr = outside_addr();
        end
        lsu_req_addr  <= addr;
        lsu_req_size  <= mem_types_pkg::access_size_e'(sz);
        lsu_req_write <= $random(seed);
        lsu_req_wdata <= {$random(seed), $random(seed)};
        lsu_req_valid <= 1'b1;
    endtask

    // a held request keeps its payload until accepted
    task automatic drive_ports();
        if (!if_req_valid || if_fire) begin
            if (mode == MODE_SAT || (mode != MODE_DRAIN && ($random(seed) & 3) != 0)) begin
                next_fetch();
            end else begin
                if_req_valid <= 1'b0;
            end
        end
        if (!lsu_req_valid || lsu_fire) begin
            if (mode == MODE_SAT || (mode != MODE_DRAIN && ($random(seed) & 3) != 0)) begin
                next_lsu();
            end else begin
                lsu_req_valid <= 1'b0;
            end
        end
        if_rsp_ready  <= (mode == MODE_RANDOM) ? $random(seed) : 1'b1;
        lsu_rsp_ready <= (mode == MODE_RANDOM) ? $random(seed) : (mode != MODE_HOLD);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            drive_ports();
        end
    end

    task automatic note_grant(input int id);
        if (count_alt) begin
            if (last_port >= 0) begin
                check_value("accepting port", id, 1 - last_port);
            end
            last_port = id;
            sat_fires++;
        end
    endtask

    task automatic watch_fetch();
        logic [32:0] exp;
        check_value("if_rsp_valid", if_rsp_valid, if_fire || if_held);
        if (if_held) begin
            check_value("if_rsp_inst held", if_rsp_inst, if_inst_prev);
            check_value("if_rsp_err held", if_rsp_err, if_err_prev);
        end
        if (if_rsp_valid) begin
            check_value("if_req_ready", if_req_ready, 1'b0);
        end
        if (if_rsp_valid && if_rsp_ready) begin
            if (if_exp_q.size() == 0) begin
                error_count++;
                $display("fetch response arrived with no request outstanding at %0t", $time);
            end else begin
                exp = if_exp_q.pop_front();
                check_value("if_rsp_err", if_rsp_err, exp[32]);
                if (!exp[32]) begin
                    check_value("if_rsp_inst", if_rsp_inst, exp[31:0]);
                end
            end
        end
        if_held      = if_rsp_valid && !if_rsp_ready;
        if_inst_prev = if_rsp_inst;
        if_err_prev  = if_rsp_err;
        if_fire      = if_req_valid && if_req_ready;
        if (if_fire) begin
            if (access_legal(if_req_addr, 4)) begin
                if_exp_q.push_back({1'b0, model_read(if_req_addr, 4)});
            end else begin
                if_exp_q.push_back({1'b1, 32'd0});
            end
            note_grant(0);
        end
    endtask

    task automatic watch_lsu();
        logic [65:0] exp;
        int          nbytes;
        check_value("lsu_rsp_valid", lsu_rsp_valid, lsu_fire || lsu_held);
        if (lsu_held) begin
            check_value("lsu_rsp_rdata held", lsu_rsp_rdata, lsu_rdata_prev);
            check_value("lsu_rsp_err held", lsu_rsp_err, lsu_err_prev);
        end
        if (lsu_rsp_valid) begin
            check_value("lsu_req_ready", lsu_req_ready, 1'b0);
        end
        if (lsu_rsp_valid && lsu_rsp_ready) begin
            if (lsu_exp_q.size() == 0) begin
                error_count++;
                $display("lsu response arrived with no request outstanding at %0t", $time);
            end else begin
                exp = lsu_exp_q.pop_front();
                check_value("lsu_rsp_err", lsu_rsp_err, exp[64]);
                if (exp[65]) begin
                    check_value("lsu_rsp_rdata", lsu_rsp_rdata, exp[63:0]);
                end
            end
        end
        lsu_held       = lsu_rsp_valid && !lsu_rsp_ready;
        lsu_rdata_prev = lsu_rsp_rdata;
        lsu_err_prev   = lsu_rsp_err;
        lsu_fire       = lsu_req_valid && lsu_req_ready;
        if (lsu_fire) begin
            nbytes = 1 << lsu_req_size;
            if (!access_legal(lsu_req_addr, nbytes)) begin
                lsu_exp_q.push_back({1'b0, 1'b1, 64'd0});
            end else if (lsu_req_write) begin
                model_write(lsu_req_addr, nbytes, lsu_req_wdata);
                lsu_exp_q.push_back({1'b0, 1'b0, 64'd0});
            end else begin
                lsu_exp_q.push_back({1'b1, 1'b0, model_read(lsu_req_addr, nbytes)});
            end
            note_grant(1);
        end
    endtask

    // everything is settled half a cycle after the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (mode == MODE_HOLD && lsu_rsp_valid && !lsu_rsp_ready) begin
                hold_cycles++;
            end
            if (mode == MODE_HOLD && if_rsp_valid && if_rsp_ready) begin
                hold_fetch_done++;
            end
            watch_fetch();
            watch_lsu();
            // saturated traffic is all legal, so only one grant per cycle
            if (count_alt) begin
                check_value("both req_ready", if_fire && lsu_fire, 1'b0);
            end
        end
    end

    initial begin
        int timer;
        for (int i = 0; i < WIN_BYTES; i++) begin
            model[i] = 8'h00;
        end
        rst_n         <= 1'b0;
        if_req_valid  <= 1'b0;
        if_req_addr   <= '0;
        if_rsp_ready  <= 1'b0;
        lsu_req_valid <= 1'b0;
        lsu_req_write <= 1'b0;
        lsu_req_addr  <= '0;
        lsu_req_size  <= mem_types_pkg::SIZE_B;
        lsu_req_wdata <= '0;
        lsu_rsp_ready <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("if_rsp_valid after reset", if_rsp_valid, 1'b0);
        check_value("lsu_rsp_valid after reset", lsu_rsp_valid, 1'b0);
        check_value("if_req_ready after reset", if_req_ready, 1'b0);
        check_value("lsu_req_ready after reset", lsu_req_ready, 1'b0);

        @(posedge clk);
        mode <= MODE_RANDOM;
        repeat (1500) @(posedge clk);

        // pending traffic drains before both ports saturate
        mode <= MODE_SAT;
        repeat (4) @(posedge clk);
        count_alt <= 1'b1;
        repeat (200) @(posedge clk);
        count_alt <= 1'b0;
        if (sat_fires < 100) begin
            error_count++;
            $display("too few accepted requests while both ports were saturated: %0d", sat_fires);
        end

        // lsu back-pressure while fetch keeps going
        mode <= MODE_HOLD;
        repeat (40) @(posedge clk);
        if (hold_cycles == 0 || hold_fetch_done == 0) begin
            error_count++;
            $display("back-pressure phase: lsu held %0d cycles, fetch completed %0d",
                     hold_cycles, hold_fetch_done);
        end
        mode <= MODE_RANDOM;
        repeat (500) @(posedge clk);

        mode  <= MODE_DRAIN;
        timer = 0;
        while ((if_exp_q.size() != 0 || lsu_exp_q.size() != 0 || if_req_valid ||
                lsu_req_valid) && timer < 200) begin
            @(posedge clk);
            timer++;
        end
        if (timer >= 200) begin
            error_count++;
            $display("timeout: responses still outstanding after the drain phase");
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
src/mem_types_pkg.sv
src/arb_types_pkg.sv
src/lsu_port.sv
src/fetch_port.sv
src/mem_arbiter.sv
src/data_ram.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - include
    files:
      - src/mem_types_pkg.sv
      - src/arb_types_pkg.sv
      - src/lsu_port.sv
      - src/fetch_port.sv
      - src/mem_arbiter.sv
      - src/data_ram.sv
      - src/mem_subsys_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_mem_subsys.sv
